//--- Bender.yml
package:
  name: lsu_mem_stage

sources:
  - include_dirs:
      - src
    files:
      - src/lsu_instr_pkg.sv
      - src/lsu_mem_pkg.sv
      - src/sb_slot_if.sv
      - src/lsq_queue.sv
      - src/sb_slot.sv
      - src/sb_drain.sv
      - src/data_mem.sv
      - src/lsu_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/tb_lsu_top.sv

//--- src/data_mem.sv
`timescale 1ns/1ps
`include "lsu_settings.svh"

module data_mem import lsu_mem_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rstn_i,

    input  logic                   wr_en_i,
    input  mem_write_t             wr_i,

    input  logic                   rd_en_i,
    input  word_addr_t             rd_addr_i,
    input  logic [`GL_INDEX_W-1:0] rd_gl_index_i,

    output logic                   load_valid_o,
    output load_result_t           load_o
);

    logic [31:0] mem [`MEM_WORDS];

    // Byte masked write, contents start at zero
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en_i) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_i.mask[b]) mem[wr_i.addr][8*b +: 8] <= wr_i.data[8*b +: 8];
            end
        end
    end

    // One cycle load latency
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) load_valid_o <= 1'b0;
        else         load_valid_o <= rd_en_i;
    end

    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            load_o.data     <= mem[rd_addr_i];
            load_o.gl_index <= rd_gl_index_i;
        end
    end

endmodule

//--- src/lsq_queue.sv
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsq_queue import lsu_instr_pkg::*, lsu_mem_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   flush_i,

    input  logic                   instr_valid_i,
    input  lsq_instr_t             instr_i,
    input  logic                   issue_i,          // Execute request for the head

    output logic                   full_o,
    output logic                   empty_o,          // Queue and store buffer both drained
    output logic                   blocked_o,
    output logic                   load_after_store_o,

    // Load read request to memory
    output logic                   rd_en_o,
    output word_addr_t             rd_addr_o,
    output logic [`GL_INDEX_W-1:0] rd_gl_index_o,

    sb_slot_if.feed                slot_if [`SB_ENTRIES-1:0]
);

    localparam int PTR_W = $clog2(`LSQ_ENTRIES);
    localparam int CNT_W = PTR_W + 1;   // One bit more than the pointers

    lsq_instr_t        control_table [`LSQ_ENTRIES];
    logic [PTR_W-1:0]  head;
    logic [PTR_W-1:0]  tail;
    logic [CNT_W-1:0]  count;

    lsq_instr_t        head_instr;
    logic              head_valid;
    logic              is_load;
    logic              is_store;
    logic              collision;

    logic [`SB_ENTRIES-1:0] busy_vec;
    logic [`SB_ENTRIES-1:0] hit_vec;
    logic [`SB_ENTRIES-1:0] free_vec;
    logic [`SB_ENTRIES-1:0] alloc_sel;

    logic push;
    logic pop;
    logic load_issue;
    logic store_move;

    // Gather slot state and drive the per slot feed signals
    for (genvar i = 0; i < `SB_ENTRIES; i++) begin : g_feed
        assign busy_vec[i]           = slot_if[i].busy;
        assign hit_vec[i]            = slot_if[i].hit;
        assign slot_if[i].alloc       = store_move & alloc_sel[i];
        assign slot_if[i].alloc_instr = head_instr;
        assign slot_if[i].probe_addr  = head_instr.addr[`ADDR_W-1:2];
    end

    // Head classification
    assign head_instr = control_table[head];
    assign head_valid = (count != '0);
    assign is_load    = head_valid & (head_instr.op == LOAD);
    assign is_store   = head_valid & (head_instr.op == STORE);
    assign collision  = is_load & (|hit_vec);

    // Lowest free slot, one-hot
    assign free_vec  = ~busy_vec;
    assign alloc_sel = free_vec & (~free_vec + 1'b1);

    assign store_move = is_store & (|free_vec) & ~flush_i;   // Independent of issue_i
    assign load_issue = issue_i & is_load & ~collision & ~flush_i;

    assign full_o = (count == `LSQ_ENTRIES);
    assign push   = instr_valid_i & ~full_o;
    assign pop    = load_issue | store_move;

    always_ff @(posedge clk_i) begin
        if (push) begin
            control_table[tail] <= instr_i;
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) tail <= tail + 1'b1;
            if (pop)  head <= head + 1'b1;
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign empty_o            = (count == '0) & ~(|busy_vec);
    assign blocked_o          = issue_i & (~head_valid | is_store | collision);
    assign load_after_store_o = collision;

    assign rd_en_o       = load_issue;
    assign rd_addr_o     = head_instr.addr[`ADDR_W-1:2];
    assign rd_gl_index_o = head_instr.gl_index;

endmodule

//--- src/lsu_instr_pkg.sv
`include "lsu_settings.svh"

package lsu_instr_pkg;

    // Kind of memory instruction held in the queue
    typedef enum logic {
        LOAD  = 1'b0,
        STORE = 1'b1
    } mem_op_e;

    // Access width, only shapes the store byte mask
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } mem_size_e;

    // One queued instruction
    typedef struct packed {
        mem_op_e                 op;
        mem_size_e               size;
        logic [`ADDR_W-1:0]      addr;     // Byte address
        logic [31:0]             data;     // Store data, unused by loads
        logic [`GL_INDEX_W-1:0]  gl_index;
    } lsq_instr_t;

endpackage

//--- src/lsu_mem_pkg.sv
`include "lsu_settings.svh"

package lsu_mem_pkg;

    // Word index into the data memory
    typedef logic [`ADDR_W-3:0] word_addr_t;

    typedef logic [3:0] byte_mask_t;   // One bit per byte lane

    // Masked write into one memory word
    typedef struct packed {
        word_addr_t  addr;
        byte_mask_t  mask;
        logic [31:0] data;   // Already shifted into lane position
    } mem_write_t;

    // Word returned by a load, tagged with its global index
    typedef struct packed {
        logic [31:0]            data;
        logic [`GL_INDEX_W-1:0] gl_index;
    } load_result_t;

endpackage

//--- src/lsu_settings.svh
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// Queue and store buffer sizing
`define LSQ_ENTRIES 8
`define SB_ENTRIES  4

// Global reorder index width
`define GL_INDEX_W 6

// Byte address width, memory is word addressed below it
`define ADDR_W    10
`define MEM_WORDS (1 << (`ADDR_W - 2))

`endif

//--- src/lsu_top.sv
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_top import lsu_instr_pkg::*, lsu_mem_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   flush_i,

    input  logic                   instr_valid_i,
    input  mem_op_e                instr_op_i,
    input  mem_size_e              instr_size_i,
    input  logic [`ADDR_W-1:0]     instr_addr_i,
    input  logic [31:0]            instr_data_i,
    input  logic [`GL_INDEX_W-1:0] instr_gl_index_i,

    input  logic                   issue_i,
    input  logic                   commit_valid_i,
    input  logic [`GL_INDEX_W-1:0] commit_gl_index_i,

    output logic                   full_o,
    output logic                   empty_o,
    output logic                   blocked_o,
    output logic                   load_after_store_o,

    output logic                   load_valid_o,
    output logic [31:0]            load_data_o,
    output logic [`GL_INDEX_W-1:0] load_gl_index_o,

    output logic                   store_done_o,
    output logic [`GL_INDEX_W-1:0] store_done_gl_index_o
);

    lsq_instr_t             instr;
    logic                   rd_en;
    word_addr_t             rd_addr;
    logic [`GL_INDEX_W-1:0] rd_gl_index;
    logic                   wr_en;
    mem_write_t             wr;
    load_result_t           load_result;

    sb_slot_if slot_if [`SB_ENTRIES-1:0] ();

    assign instr.op       = instr_op_i;
    assign instr.size     = instr_size_i;
    assign instr.addr     = instr_addr_i;
    assign instr.data     = instr_data_i;
    assign instr.gl_index = instr_gl_index_i;

    lsq_queue u_queue (
        .clk_i, .rstn_i, .flush_i,
        .instr_valid_i, .instr_i(instr), .issue_i,
        .full_o, .empty_o, .blocked_o, .load_after_store_o,
        .rd_en_o(rd_en), .rd_addr_o(rd_addr), .rd_gl_index_o(rd_gl_index),
        .slot_if(slot_if)
    );

    for (genvar i = 0; i < `SB_ENTRIES; i++) begin : g_sb
        sb_slot u_slot (.clk_i, .rstn_i, .flush_i, .slot_if(slot_if[i]));
    end

    sb_drain u_drain (
        .clk_i, .rstn_i, .commit_valid_i, .commit_gl_index_i,
        .slot_if(slot_if),
        .wr_en_o(wr_en), .wr_o(wr),
        .store_done_o, .store_done_gl_index_o
    );

    data_mem u_mem (
        .clk_i, .rstn_i, .wr_en_i(wr_en), .wr_i(wr),
        .rd_en_i(rd_en), .rd_addr_i(rd_addr), .rd_gl_index_i(rd_gl_index),
        .load_valid_o, .load_o(load_result)
    );

    // Result back onto plain ports
    assign load_data_o     = load_result.data;
    assign load_gl_index_o = load_result.gl_index;

endmodule

//--- src/sb_drain.sv
`timescale 1ns/1ps
`include "lsu_settings.svh"

module sb_drain import lsu_instr_pkg::*, lsu_mem_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rstn_i,

    input  logic                   commit_valid_i,
    input  logic [`GL_INDEX_W-1:0] commit_gl_index_i,

    sb_slot_if.drain               slot_if [`SB_ENTRIES-1:0],

    output logic                   wr_en_o,
    output mem_write_t             wr_o,

    output logic                   store_done_o,
    output logic [`GL_INDEX_W-1:0] store_done_gl_index_o
);

    logic [`SB_ENTRIES-1:0] match_vec;
    lsq_instr_t             entries [`SB_ENTRIES];
    lsq_instr_t             sel;
    logic [1:0]             lane;       // Lowest byte lane touched
    byte_mask_t             base_mask;

    // Broadcast the commit, collect the answers
    for (genvar i = 0; i < `SB_ENTRIES; i++) begin : g_slot
        assign slot_if[i].commit_valid    = commit_valid_i;
        assign slot_if[i].commit_gl_index = commit_gl_index_i;
        assign slot_if[i].release_en      = match_vec[i];   // Free on the write edge
        assign match_vec[i]               = slot_if[i].match;
        assign entries[i]                 = slot_if[i].entry;
    end

    // At most one slot matches
    always_comb begin
        sel = '0;
        for (int i = 0; i < `SB_ENTRIES; i++) begin
            if (match_vec[i]) sel = entries[i];
        end
    end

    always_comb begin
        case (sel.size)
            BYTE: begin
                lane      = sel.addr[1:0];
                base_mask = 4'b0001;
            end
            HALF: begin
                lane      = {sel.addr[1], 1'b0};   // Halfword aligned
                base_mask = 4'b0011;
            end
            default: begin
                lane      = 2'b00;
                base_mask = 4'b1111;
            end
        endcase
    end

    assign wr_en_o     = |match_vec;
    assign wr_o.addr   = sel.addr[`ADDR_W-1:2];
    assign wr_o.mask   = base_mask << lane;
    assign wr_o.data   = sel.data << {lane, 3'b000};

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            store_done_o <= 1'b0;
        end else begin
            store_done_o <= wr_en_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en_o) begin
            store_done_gl_index_o <= sel.gl_index;
        end
    end

endmodule

//--- src/sb_slot.sv
`timescale 1ns/1ps
`include "lsu_settings.svh"

module sb_slot import lsu_instr_pkg::*, lsu_mem_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  logic     flush_i,
    sb_slot_if.slot  slot_if
);

    logic       busy_q;
    lsq_instr_t entry_q;
    word_addr_t entry_word;

    // Occupancy flag
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            busy_q <= 1'b0;
        end else if (flush_i || slot_if.release_en) begin
            busy_q <= 1'b0;
        end else if (slot_if.alloc) begin
            busy_q <= 1'b1;
        end
    end

    // Captured store, valid only while busy
    always_ff @(posedge clk_i) begin
        if (slot_if.alloc) begin
            entry_q <= slot_if.alloc_instr;
        end
    end

    assign entry_word = entry_q.addr[`ADDR_W-1:2];

    assign slot_if.busy  = busy_q;
    assign slot_if.entry = entry_q;

    // Same word as the head load
    assign slot_if.hit = busy_q & (entry_word == slot_if.probe_addr);

    // A flush in the same cycle cancels the commit write
    assign slot_if.match = busy_q & slot_if.commit_valid & ~flush_i
                         & (entry_q.gl_index == slot_if.commit_gl_index);

endmodule

//--- src/sb_slot_if.sv
`timescale 1ns/1ps
`include "lsu_settings.svh"

interface sb_slot_if import lsu_instr_pkg::*, lsu_mem_pkg::*; ();

    // Queue side
    logic                   alloc;
    lsq_instr_t             alloc_instr;
    word_addr_t             probe_addr;   // Word of the load at the queue head

    // Slot state
    logic                   busy;
    logic                   hit;
    logic                   match;
    lsq_instr_t             entry;

    // Commit side
    logic                   release_en;
    logic                   commit_valid;
    logic [`GL_INDEX_W-1:0] commit_gl_index;

    modport feed  (output alloc, alloc_instr, probe_addr,
                   input  busy, hit);

    modport slot  (output busy, hit, match, entry,
                   input  alloc, alloc_instr, probe_addr, release_en,
                          commit_valid, commit_gl_index);

    modport drain (output release_en, commit_valid, commit_gl_index,
                   input  match, entry);

endinterface

//--- tb/tb_lsu_top.sv
`timescale 1ns/1ps
`include "lsu_settings.svh"

module tb_lsu_top import lsu_instr_pkg::*, lsu_mem_pkg::*; ();

    typedef logic [`GL_INDEX_W-1:0] gl_index_t;

    localparam int NUM_TESTS   = 6;
    localparam int CYCLE_LIMIT = 40 * NUM_TESTS;

    logic               clk_i;
    logic               rstn_i;
    logic               flush_i;
    logic               instr_valid_i;
    mem_op_e            instr_op_i;
    mem_size_e          instr_size_i;
    logic [`ADDR_W-1:0] instr_addr_i;
    logic [31:0]        instr_data_i;
    gl_index_t          instr_gl_index_i;
    logic               issue_i;
    logic               commit_valid_i;
    gl_index_t          commit_gl_index_i;
    logic               full_o;
    logic               empty_o;
    logic               blocked_o;
    logic               load_after_store_o;
    logic               load_valid_o;
    logic [31:0]        load_data_o;
    gl_index_t          load_gl_index_o;
    logic               store_done_o;
    gl_index_t          store_done_gl_index_o;

    logic [31:0]        ref_mem [`MEM_WORDS];   // Updated only at commit
    logic [`ADDR_W-1:0] st_addr [1 << `GL_INDEX_W];
    mem_size_e          st_size [1 << `GL_INDEX_W];
    logic [31:0]        st_data [1 << `GL_INDEX_W];
    load_result_t       load_q [$];
    gl_index_t          next_gl;
    int                 errors;
    int                 checks;
    int                 tests_run;
    int                 tests_failed;
    int                 cycles;
    int                 err_before;

    lsu_top lsu_top_i (.*);

    always #50 clk_i = ~clk_i;

    // Collect load results away from the driving edge
    always @(negedge clk_i) begin
        if (rstn_i && load_valid_o) load_q.push_back({load_data_o, load_gl_index_o});
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("Test failed");
            $finish;
        end
    end

    task automatic check_load(input load_result_t got, input load_result_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0d ns: load expected data %h index %0d, got data %h index %0d",
                     $time, exp.data, exp.gl_index, got.data, got.gl_index);
        end
    endtask

    task automatic check_store_done(input gl_index_t got, input gl_index_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0d ns: store done index expected %0d, got %0d",
                     $time, exp, got);
        end
    endtask

    // Order is full, empty, blocked, load after store
    task automatic check_flags(input logic e_full, input logic e_empty,
                               input logic e_blocked, input logic e_las);
        checks++;
        if ({full_o, empty_o, blocked_o, load_after_store_o} !==
            {e_full, e_empty, e_blocked, e_las}) begin
            errors++;
            $display("mismatch at %0d ns: flags expected %b%b%b%b, got %b%b%b%b", $time,
                     e_full, e_empty, e_blocked, e_las,
                     full_o, empty_o, blocked_o, load_after_store_o);
        end
    endtask

    // Byte lanes follow the access size and the low address bits
    task automatic model_store(input gl_index_t gl);
        word_addr_t w;
        int         first;
        int         nbytes;
        w = st_addr[gl][`ADDR_W-1:2];
        case (st_size[gl])
            BYTE: begin
                first  = st_addr[gl][1:0];
                nbytes = 1;
            end
            HALF: begin
                first  = st_addr[gl][1] ? 2 : 0;
                nbytes = 2;
            end
            default: begin
                first  = 0;
                nbytes = 4;
            end
        endcase
        for (int b = 0; b < nbytes; b++) begin
            ref_mem[w][8*(first+b) +: 8] = st_data[gl][8*b +: 8];
        end
    endtask

    task automatic drive_instr(input mem_op_e op, input mem_size_e size,
                               input logic [`ADDR_W-1:0] addr, input logic [31:0] data,
                               input gl_index_t gl);
        instr_valid_i    <= 1'b1;
        instr_op_i       <= op;
        instr_size_i     <= size;
        instr_addr_i     <= addr;
        instr_data_i     <= data;
        instr_gl_index_i <= gl;
    endtask

    // Holds the input until the queue has room
    task automatic push_instr(input mem_op_e op, input mem_size_e size,
                              input logic [`ADDR_W-1:0] addr, input logic [31:0] data,
                              input gl_index_t gl);
        @(posedge clk_i);
        drive_instr(op, size, addr, data, gl);
        @(negedge clk_i);
        while (full_o) @(negedge clk_i);
        @(posedge clk_i);
        instr_valid_i <= 1'b0;
    endtask

    task automatic push_load(input word_addr_t w, output gl_index_t gl);
        gl      = next_gl;
        next_gl = next_gl + 1'b1;
        push_instr(LOAD, WORD, {w, 2'($urandom_range(3, 0))}, 32'h0, gl);
    endtask

    task automatic push_store(input word_addr_t w, output gl_index_t gl);
        gl          = next_gl;
        next_gl     = next_gl + 1'b1;
        st_size[gl] = mem_size_e'($urandom_range(2, 0));
        st_addr[gl] = {w, 2'($urandom_range(3, 0))};
        st_data[gl] = $urandom();
        push_instr(STORE, st_size[gl], st_addr[gl], st_data[gl], gl);
    endtask

    task automatic issue_loads(input int n);
        int issued;
        issued = 0;
        @(posedge clk_i);
        issue_i <= 1'b1;
        while (issued < n) begin
            @(negedge clk_i);
            if (!blocked_o) issued++;   // Head load leaves on the coming edge
            @(posedge clk_i);
        end
        issue_i <= 1'b0;
    endtask

    task automatic expect_load(input word_addr_t w, input gl_index_t gl);
        load_result_t exp;
        int           waited;
        exp.data     = ref_mem[w];
        exp.gl_index = gl;
        waited       = 0;
        while (load_q.size() == 0 && waited < 10) begin
            @(posedge clk_i);
            waited++;
        end
        if (load_q.size() == 0) begin
            errors++;
            $display("No load result arrived for global index %0d", gl);
        end else begin
            check_load(load_q.pop_front(), exp);
        end
    endtask

    task automatic commit_store(input gl_index_t gl);
        int waited;
        waited = 0;
        @(posedge clk_i);
        commit_valid_i    <= 1'b1;
        commit_gl_index_i <= gl;
        @(negedge clk_i);
        while (!store_done_o && waited < 10) begin
            @(negedge clk_i);
            waited++;
        end
        if (!store_done_o) begin
            errors++;
            $display("No store done pulse after commit of global index %0d", gl);
        end else begin
            check_store_done(store_done_gl_index_o, gl);
            model_store(gl);
        end
        @(posedge clk_i);
        commit_valid_i <= 1'b0;
    endtask

    task automatic expect_no_load(input string what);
        if (load_q.size() != 0) begin
            errors++;
            $display("Unexpected load result: %s", what);
            load_q.delete();
        end
    endtask

    task automatic test_reset_fill();
        word_addr_t w [`LSQ_ENTRIES];
        gl_index_t  g [`LSQ_ENTRIES];
        @(negedge clk_i);
        check_flags(1'b0, 1'b1, 1'b0, 1'b0);
        for (int i = 0; i < `LSQ_ENTRIES; i++) begin
            w[i] = word_addr_t'($urandom_range(`MEM_WORDS - 1, 0));
            push_load(w[i], g[i]);
        end
        @(posedge clk_i);
        drive_instr(LOAD, WORD, '0, 32'h0, next_gl);   // Must be dropped while full
        repeat (3) begin
            @(negedge clk_i);
            check_flags(1'b1, 1'b0, 1'b0, 1'b0);
        end
        @(posedge clk_i);
        instr_valid_i <= 1'b0;
        issue_loads(`LSQ_ENTRIES);
        for (int i = 0; i < `LSQ_ENTRIES; i++) expect_load(w[i], g[i]);
        @(posedge clk_i);
        issue_i <= 1'b1;   // An accepted extra load would leave here
        repeat (3) @(posedge clk_i);
        issue_i <= 1'b0;
        @(posedge clk_i);
        expect_no_load("input accepted while the queue was full");
        @(negedge clk_i);
        check_flags(1'b0, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic test_store_commit();
        word_addr_t w [`SB_ENTRIES];
        gl_index_t  gs [`SB_ENTRIES];
        gl_index_t  gl [`SB_ENTRIES];
        for (int i = 0; i < `SB_ENTRIES; i++) begin
            w[i] = word_addr_t'($urandom_range(15, 0));
            push_store(w[i], gs[i]);
        end
        for (int i = 0; i < `SB_ENTRIES; i++) commit_store(gs[i]);
        for (int i = 0; i < `SB_ENTRIES; i++) push_load(w[i], gl[i]);
        issue_loads(`SB_ENTRIES);
        for (int i = 0; i < `SB_ENTRIES; i++) expect_load(w[i], gl[i]);
        @(negedge clk_i);
        check_flags(1'b0, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic test_load_pipeline();
        word_addr_t w [4];
        gl_index_t  g [4];
        for (int i = 0; i < 4; i++) begin
            w[i] = word_addr_t'($urandom_range(15, 0));   // Words written by earlier stores
            push_load(w[i], g[i]);
        end
        issue_loads(4);
        for (int i = 0; i < 4; i++) expect_load(w[i], g[i]);
    endtask

    task automatic test_load_after_store();
        gl_index_t gs;
        gl_index_t gl;
        push_store(8'd50, gs);
        push_load(8'd50, gl);
        @(posedge clk_i);
        issue_i <= 1'b1;
        repeat (3) begin
            @(negedge clk_i);
            check_flags(1'b0, 1'b0, 1'b1, 1'b1);
        end
        @(posedge clk_i);
        issue_i <= 1'b0;
        expect_no_load("load passed a waiting store to the same word");
        commit_store(gs);
        issue_loads(1);
        expect_load(8'd50, gl);
        // A load to another word is not held back
        push_store(8'd50, gs);
        push_load(8'd51, gl);
        @(posedge clk_i);
        issue_i <= 1'b1;
        @(negedge clk_i);
        check_flags(1'b0, 1'b0, 1'b0, 1'b0);
        @(posedge clk_i);
        issue_i <= 1'b0;
        expect_load(8'd51, gl);
        commit_store(gs);
    endtask

    task automatic test_buffer_full();
        gl_index_t gs [`SB_ENTRIES+1];
        gl_index_t gl;
        for (int i = 0; i <= `SB_ENTRIES; i++) push_store(word_addr_t'(60 + i), gs[i]);
        push_load(8'd70, gl);
        @(posedge clk_i);
        issue_i <= 1'b1;
        repeat (2) begin
            @(negedge clk_i);
            check_flags(1'b0, 1'b0, 1'b1, 1'b0);   // Last store still at the head
        end
        @(posedge clk_i);
        issue_i <= 1'b0;
        expect_no_load("load passed a store held at the head");
        commit_store(gs[0]);
        issue_loads(1);
        expect_load(8'd70, gl);
        for (int i = 1; i <= `SB_ENTRIES; i++) commit_store(gs[i]);
        @(negedge clk_i);
        check_flags(1'b0, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic test_flush();
        gl_index_t g [4];
        push_store(8'd80, g[0]);
        push_store(8'd81, g[1]);
        push_load(8'd5, g[2]);
        push_load(8'd80, g[3]);
        @(posedge clk_i);
        flush_i           <= 1'b1;
        issue_i           <= 1'b1;   // Head load and commit both cancelled by the flush
        commit_valid_i    <= 1'b1;
        commit_gl_index_i <= g[0];
        @(posedge clk_i);
        flush_i        <= 1'b0;
        issue_i        <= 1'b0;
        commit_valid_i <= 1'b0;
        @(negedge clk_i);
        check_flags(1'b0, 1'b1, 1'b0, 1'b0);
        @(posedge clk_i);
        expect_no_load("load issued in the flush cycle");
        push_load(8'd80, g[0]);
        push_load(8'd81, g[1]);
        push_load(8'd5, g[2]);
        issue_loads(3);
        expect_load(8'd80, g[0]);
        expect_load(8'd81, g[1]);
        expect_load(8'd5, g[2]);
    endtask

    task automatic report_test(input string name, input int err_start);
        tests_run++;
        if (errors == err_start) begin
            $display("%-20s ok", name);
        end else begin
            tests_failed++;
            $display("%-20s %0d errors", name, errors - err_start);
        end
    endtask

    initial begin
        int unsigned seed;
        seed = 32'hed42_eae2;
        void'($urandom(seed));
        clk_i             = 1'b0;
        rstn_i            = 1'b0;
        flush_i           = 1'b0;
        instr_valid_i     = 1'b0;
        instr_op_i        = LOAD;
        instr_size_i      = WORD;
        instr_addr_i      = '0;
        instr_data_i      = '0;
        instr_gl_index_i  = '0;
        issue_i           = 1'b0;
        commit_valid_i    = 1'b0;
        commit_gl_index_i = '0;
        next_gl           = '0;
        errors            = 0;
        checks            = 0;
        tests_run         = 0;
        tests_failed      = 0;
        cycles            = 0;
        for (int i = 0; i < `MEM_WORDS; i++) ref_mem[i] = '0;
        repeat (4) @(posedge clk_i);
        rstn_i <= 1'b1;

        err_before = errors;
        test_reset_fill();
        report_test("reset_fill", err_before);
        err_before = errors;
        test_store_commit();
        report_test("store_commit", err_before);
        err_before = errors;
        test_load_pipeline();
        report_test("load_pipeline", err_before);
        err_before = errors;
        test_load_after_store();
        report_test("load_after_store", err_before);
        err_before = errors;
        test_buffer_full();
        report_test("buffer_full", err_before);
        err_before = errors;
        test_flush();
        report_test("flush", err_before);

        $display("Tests run: %0d, tests failing: %0d, checks: %0d, errors: %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+src
src/lsu_instr_pkg.sv
src/lsu_mem_pkg.sv
src/sb_slot_if.sv
src/lsq_queue.sv
src/sb_slot.sv
src/sb_drain.sv
src/data_mem.sv
src/lsu_top.sv
tb/tb_lsu_top.sv
